/* src/mm_defines.svh */
/*
 * matrix-multiply accelerator parameters
 * element, systolic, buffer and burst sizes shared by all blocks
 */
`ifndef MM_DEFINES_SVH
`define MM_DEFINES_SVH

// signed element width of A, B and C
`define MM_DW           32

// systolic width, matrices are fixed at this size
`define MM_SA_WIDTH     4

// operand buffer, one entry per column of A or row of B
`define MM_BUF_AW       2
`define MM_BUF_DW       (`MM_SA_WIDTH * `MM_DW)

// accumulator keeps full product plus carry headroom
`define MM_ACC_W        (2 * `MM_DW + 1)

// beats per read or write burst, one matrix each
`define MM_BURST_LEN    16

`endif

/* src/mm_pkg.sv */
/*
 * shared types for the matrix-multiply accelerator
 * AXI-style channel payloads, buffer write and accumulator matrix
 */
`include "mm_defines.svh"

package mm_pkg;

    // read request
    typedef struct packed {
        logic [31:0] addr;
        logic        id;
        logic [3:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_ar_t;

    // read data beat
    typedef struct packed {
        logic [`MM_DW-1:0] data;
        logic              id;
        logic              last;
    } axi_r_t;

    // write request, same layout as a read request
    typedef struct packed {
        logic [31:0] addr;
        logic        id;
        logic [3:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_aw_t;

    // write data beat
    typedef struct packed {
        logic [`MM_DW-1:0]   data;
        logic [`MM_DW/8-1:0] strb;
        logic                last;
    } axi_w_t;

    // one full entry into an operand buffer
    typedef struct packed {
        logic                  en;
        logic [`MM_BUF_AW-1:0] addr;
        logic [`MM_BUF_DW-1:0] data;
    } buf_wr_t;

    // single accumulator and the full row x column grid
    typedef logic signed [`MM_ACC_W-1:0] accum_t;
    typedef accum_t [`MM_SA_WIDTH-1:0][`MM_SA_WIDTH-1:0] accum_mat_t;

endpackage

/* src/dma_engine.sv */
/*
 * DMA engine for the matrix multiplier
 * fetches A and B by read bursts, fills both operand buffers,
 * starts the multiply and writes C back as one write burst
 */
`timescale 1ns/1ns
`include "mm_defines.svh"

module dma_engine (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_i,
    input  logic [31:0]          mat_a_addr_i,
    input  logic [31:0]          mat_b_addr_i,
    input  logic [31:0]          mat_c_addr_i,
    output logic                 done_o,
    // read address / data
    output mm_pkg::axi_ar_t      ar_o,
    output logic                 arvalid_o,
    input  logic                 arready_i,
    input  mm_pkg::axi_r_t       r_i,
    input  logic                 rvalid_i,
    output logic                 rready_o,
    // write address / data / response
    output mm_pkg::axi_aw_t      aw_o,
    output logic                 awvalid_o,
    input  logic                 awready_i,
    output mm_pkg::axi_w_t       w_o,
    output logic                 wvalid_o,
    input  logic                 wready_i,
    input  logic                 bvalid_i,
    output logic                 bready_o,
    // operand buffers
    output mm_pkg::buf_wr_t      buf_a_wr_o,
    output mm_pkg::buf_wr_t      buf_b_wr_o,
    // multiply engine
    output logic                 mm_start_o,
    input  logic                 mm_done_i,
    input  mm_pkg::accum_mat_t   accum_i
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_REQ_A,
        ST_REQ_B,
        ST_LOAD,
        ST_WAIT_MM,
        ST_REQ_C,
        ST_WRITE_C
    } state_t;

    state_t state_q;

    // host addresses held for the whole operation
    logic [31:0] a_addr_q;
    logic [31:0] b_addr_q;
    logic [31:0] c_addr_q;

    // per-id assembler state, index = read id
    logic [`MM_BUF_DW-1:0] asm_q     [2];
    logic [1:0]            beat_q    [2];
    logic [2:0]            ent_q     [2];
    logic                  wr_en_q   [2];
    logic [`MM_BUF_AW-1:0] wr_addr_q [2];

    // W beat counter, bit 4 set once all 16 are sent
    logic [4:0] w_cnt_q;

    logic r_hs;
    logic w_hs;
    logic start_go;

    assign start_go = (state_q == ST_IDLE) && start_i;
    assign r_hs     = rvalid_i && rready_o;
    assign w_hs     = wvalid_o && wready_i;

    // control FSM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= ST_IDLE;
            w_cnt_q    <= '0;
            mm_start_o <= 1'b0;
        end else begin
            mm_start_o <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        state_q <= ST_REQ_A;
                        w_cnt_q <= '0;
                    end
                end
                ST_REQ_A: begin
                    if (arready_i) begin
                        state_q <= ST_REQ_B;
                    end
                end
                ST_REQ_B: begin
                    if (arready_i) begin
                        state_q <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    // both buffers full, last entry is being written now
                    if (ent_q[0] == 3'd4 && ent_q[1] == 3'd4) begin
                        state_q    <= ST_WAIT_MM;
                        mm_start_o <= 1'b1;
                    end
                end
                ST_WAIT_MM: begin
                    if (mm_done_i) begin
                        state_q <= ST_REQ_C;
                    end
                end
                ST_REQ_C: begin
                    if (awready_i) begin
                        state_q <= ST_WRITE_C;
                    end
                end
                ST_WRITE_C: begin
                    if (w_hs) begin
                        w_cnt_q <= w_cnt_q + 5'd1;
                    end
                    if (bvalid_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // latch host addresses on start
    always_ff @(posedge clk) begin
        if (start_go) begin
            a_addr_q <= mat_a_addr_i;
            b_addr_q <= mat_b_addr_i;
            c_addr_q <= mat_c_addr_i;
        end
    end

    // beat assemblers, g = 0 feeds A and g = 1 feeds B
    for (genvar g = 0; g < 2; g++) begin : g_asm
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                beat_q[g]  <= '0;
                ent_q[g]   <= '0;
                wr_en_q[g] <= 1'b0;
            end else begin
                wr_en_q[g] <= 1'b0;
                if (start_go) begin
                    beat_q[g] <= '0;
                    ent_q[g]  <= '0;
                end else if (r_hs && r_i.id == 1'(g)) begin
                    beat_q[g] <= beat_q[g] + 2'd1;
                    // fourth beat completes an entry
                    if (beat_q[g] == 2'd3) begin
                        wr_en_q[g] <= 1'b1;
                        ent_q[g]   <= ent_q[g] + 3'd1;
                    end
                end
            end
        end

        // first beat shifts up into the top lane
        always_ff @(posedge clk) begin
            if (r_hs && r_i.id == 1'(g)) begin
                asm_q[g] <= {asm_q[g][`MM_BUF_DW-`MM_DW-1:0], r_i.data};
                if (beat_q[g] == 2'd3) begin
                    wr_addr_q[g] <= ent_q[g][`MM_BUF_AW-1:0];
                end
            end
        end
    end

    // buffer write ports, data is the completed assembler
    always_comb begin
        buf_a_wr_o.en   = wr_en_q[0];
        buf_a_wr_o.addr = wr_addr_q[0];
        buf_a_wr_o.data = asm_q[0];
        buf_b_wr_o.en   = wr_en_q[1];
        buf_b_wr_o.addr = wr_addr_q[1];
        buf_b_wr_o.data = asm_q[1];
    end

    // read requests, id follows the operand
    always_comb begin
        arvalid_o = (state_q == ST_REQ_A) || (state_q == ST_REQ_B);
        ar_o.addr  = (state_q == ST_REQ_B) ? b_addr_q : a_addr_q;
        ar_o.id    = (state_q == ST_REQ_B);
        ar_o.len   = 4'(`MM_BURST_LEN - 1);
        ar_o.size  = 3'd2;
        ar_o.burst = 2'b01;
        // never stalls data once the requests go out
        rready_o   = (state_q == ST_REQ_B) || (state_q == ST_LOAD);
    end

    // write request and data for C
    always_comb begin
        awvalid_o  = (state_q == ST_REQ_C);
        aw_o.addr  = c_addr_q;
        aw_o.id    = 1'b0;
        aw_o.len   = 4'(`MM_BURST_LEN - 1);
        aw_o.size  = 3'd2;
        aw_o.burst = 2'b01;
        wvalid_o   = (state_q == ST_WRITE_C) && !w_cnt_q[4];
        // beat n carries C[n/4][n%4], low word only
        w_o.data   = accum_i[w_cnt_q[3:2]][w_cnt_q[1:0]][`MM_DW-1:0];
        w_o.strb   = '1;
        w_o.last   = (w_cnt_q[3:0] == 4'(`MM_BURST_LEN - 1));
        bready_o   = (state_q == ST_WRITE_C);
        done_o     = (state_q == ST_WRITE_C) && bvalid_i;
    end

endmodule

/* src/mat_buffer.sv */
/*
 * operand buffer
 * four 128-bit entries, full-width write, registered read
 */
`timescale 1ns/1ns
`include "mm_defines.svh"

module mat_buffer (
    input  logic                  clk,
    input  mm_pkg::buf_wr_t       wr_i,
    input  logic [`MM_BUF_AW-1:0] raddr_i,
    output logic [`MM_BUF_DW-1:0] rdata_o
);

    // one entry per column of A or row of B
    logic [`MM_BUF_DW-1:0] mem_q [2**`MM_BUF_AW];

    // write lands at the edge
    always_ff @(posedge clk) begin
        if (wr_i.en) begin
            mem_q[wr_i.addr] <= wr_i.data;
        end
    end

    // read data one cycle after address
    always_ff @(posedge clk) begin
        rdata_o <= mem_q[raddr_i];
    end

endmodule

/* src/mm_engine.sv */
/*
 * multiply engine, 4x4 grid of signed multiply-accumulate cells
 * each buffer entry pair adds one outer product to the grid
 */
`timescale 1ns/1ns
`include "mm_defines.svh"

module mm_engine (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start_i,
    output logic [`MM_BUF_AW-1:0] raddr_o,
    input  logic [`MM_BUF_DW-1:0] a_col_i,
    input  logic [`MM_BUF_DW-1:0] b_row_i,
    output logic                  done_o,
    output wire mm_pkg::accum_mat_t accum_o
);

    // read sequencer
    logic                  issue_q;
    logic [`MM_BUF_AW-1:0] step_q;
    // entry on a_col_i / b_row_i is valid this cycle
    logic                  vld_q;
    // that entry is the last one
    logic                  last_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue_q <= 1'b0;
            step_q  <= '0;
            vld_q   <= 1'b0;
            last_q  <= 1'b0;
            done_o  <= 1'b0;
        end else begin
            vld_q  <= issue_q;
            last_q <= issue_q && (step_q == '1);
            // done follows the final accumulate
            done_o <= last_q;
            if (start_i) begin
                issue_q <= 1'b1;
                step_q  <= '0;
            end else if (issue_q) begin
                step_q <= step_q + 1'b1;
                if (step_q == '1) begin
                    issue_q <= 1'b0;
                end
            end
        end
    end

    // same address to both buffers
    assign raddr_o = step_q;

    // cell (i, j) takes row i of the A column and column j of the B row
    for (genvar i = 0; i < `MM_SA_WIDTH; i++) begin : g_row
        for (genvar j = 0; j < `MM_SA_WIDTH; j++) begin : g_col
            logic signed [`MM_DW-1:0]   a_el;
            logic signed [`MM_DW-1:0]   b_el;
            logic signed [2*`MM_DW-1:0] prod;
            logic signed [`MM_ACC_W-1:0] acc_q;

            // row 0 / column 0 sit in the top lane
            assign a_el = a_col_i[(`MM_SA_WIDTH-1-i)*`MM_DW +: `MM_DW];
            assign b_el = b_row_i[(`MM_SA_WIDTH-1-j)*`MM_DW +: `MM_DW];
            assign prod = a_el * b_el;

            // cleared on start, held after the last entry
            always_ff @(posedge clk) begin
                if (start_i) begin
                    acc_q <= '0;
                end else if (vld_q) begin
                    acc_q <= acc_q + prod;
                end
            end

            assign accum_o[i][j] = acc_q;
        end
    end

endmodule

/* src/mm_top.sv */
/*
 * matrix-multiply accelerator top
 * DMA engine, two operand buffers and the multiply engine
 */
`timescale 1ns/1ns
`include "mm_defines.svh"

module mm_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start_i,
    output logic              done_o,
    input  logic [31:0]       mat_a_addr_i,
    input  logic [31:0]       mat_b_addr_i,
    input  logic [31:0]       mat_c_addr_i,
    // read channels
    output mm_pkg::axi_ar_t   ar_o,
    output logic              arvalid_o,
    input  logic              arready_i,
    input  mm_pkg::axi_r_t    r_i,
    input  logic              rvalid_i,
    output logic              rready_o,
    // write channels
    output mm_pkg::axi_aw_t   aw_o,
    output logic              awvalid_o,
    input  logic              awready_i,
    output mm_pkg::axi_w_t    w_o,
    output logic              wvalid_o,
    input  logic              wready_i,
    input  logic              bvalid_i,
    output logic              bready_o
);

    mm_pkg::buf_wr_t       buf_a_wr;
    mm_pkg::buf_wr_t       buf_b_wr;
    logic [`MM_BUF_AW-1:0] mm_raddr;
    logic [`MM_BUF_DW-1:0] a_col;
    logic [`MM_BUF_DW-1:0] b_row;
    logic                  mm_start;
    logic                  mm_done;
    mm_pkg::accum_mat_t    accum;

    dma_engine u_dma (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .mat_a_addr_i (mat_a_addr_i),
        .mat_b_addr_i (mat_b_addr_i),
        .mat_c_addr_i (mat_c_addr_i),
        .done_o       (done_o),
        .ar_o         (ar_o),
        .arvalid_o    (arvalid_o),
        .arready_i    (arready_i),
        .r_i          (r_i),
        .rvalid_i     (rvalid_i),
        .rready_o     (rready_o),
        .aw_o         (aw_o),
        .awvalid_o    (awvalid_o),
        .awready_i    (awready_i),
        .w_o          (w_o),
        .wvalid_o     (wvalid_o),
        .wready_i     (wready_i),
        .bvalid_i     (bvalid_i),
        .bready_o     (bready_o),
        .buf_a_wr_o   (buf_a_wr),
        .buf_b_wr_o   (buf_b_wr),
        .mm_start_o   (mm_start),
        .mm_done_i    (mm_done),
        .accum_i      (accum)
    );

    // A columns
    mat_buffer u_buf_a (
        .clk     (clk),
        .wr_i    (buf_a_wr),
        .raddr_i (mm_raddr),
        .rdata_o (a_col)
    );

    // B rows
    mat_buffer u_buf_b (
        .clk     (clk),
        .wr_i    (buf_b_wr),
        .raddr_i (mm_raddr),
        .rdata_o (b_row)
    );

    mm_engine u_mm (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (mm_start),
        .raddr_o (mm_raddr),
        .a_col_i (a_col),
        .b_row_i (b_row),
        .done_o  (mm_done),
        .accum_o (accum)
    );

endmodule

/* dv/axi_mem_model.sv */
/*
 * AXI-style memory slave for the testbench
 * serves in-order read bursts, stores write bursts, stalls on request
 */
`timescale 1ns/1ns
`include "mm_defines.svh"

module axi_mem_model (
    input  logic            clk,
    input  logic            rst_n,
    // stall and bubble controls from the testbench LFSR
    input  logic            ar_stall_i,
    input  logic            aw_stall_i,
    input  logic            w_stall_i,
    input  logic            r_bubble_i,
    // read channels
    input  mm_pkg::axi_ar_t ar_i,
    input  logic            arvalid_i,
    output logic            arready_o,
    output mm_pkg::axi_r_t  r_o,
    output logic            rvalid_o,
    input  logic            rready_i,
    // write channels
    input  mm_pkg::axi_aw_t aw_i,
    input  logic            awvalid_i,
    output logic            awready_o,
    input  mm_pkg::axi_w_t  w_i,
    input  logic            wvalid_i,
    output logic            wready_o,
    output logic            bvalid_o,
    input  logic            bready_i
);

    localparam int MEM_WORDS = 1024;

    // word array, index is byte address bits 11:2
    logic [31:0] mem [MEM_WORDS];

    // accepted read bursts, served in order
    mm_pkg::axi_ar_t rd_q [$];
    int              rd_beat;
    logic [9:0]      wr_idx;

    mm_pkg::axi_r_t  r_q      = '0;
    logic            rvalid_q = 1'b0;
    logic            bvalid_q = 1'b0;

    assign r_o       = r_q;
    assign rvalid_o  = rvalid_q;
    assign bvalid_o  = bvalid_q;
    assign arready_o = !ar_stall_i;
    assign awready_o = !aw_stall_i;
    assign wready_o  = !w_stall_i;

    // background pattern over the whole index
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hc0de_0000 ^ (i * 32'h0001_0001);
        end
    end

    // read side
    always @(posedge clk) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
            rd_beat = 0;
            rd_q.delete();
        end else begin
            if (arvalid_i && arready_o) begin
                rd_q.push_back(ar_i);
            end
            // beat taken, step or retire the burst
            if (rvalid_q && rready_i) begin
                if (rd_beat == `MM_BURST_LEN - 1) begin
                    void'(rd_q.pop_front());
                    rd_beat = 0;
                end else begin
                    rd_beat++;
                end
            end
            // a stalled beat holds, otherwise maybe a bubble
            if (!rvalid_q || rready_i) begin
                if (rd_q.size() > 0 && !r_bubble_i) begin
                    rvalid_q  <= 1'b1;
                    r_q.data  <= mem[rd_q[0].addr[11:2] + 10'(rd_beat)];
                    r_q.id    <= rd_q[0].id;
                    r_q.last  <= (rd_beat == `MM_BURST_LEN - 1);
                end else begin
                    rvalid_q <= 1'b0;
                end
            end
        end
    end

    // write side, one response per burst
    always @(posedge clk) begin
        if (!rst_n) begin
            bvalid_q <= 1'b0;
            wr_idx   <= '0;
        end else begin
            if (awvalid_i && awready_o) begin
                wr_idx <= aw_i.addr[11:2];
            end
            if (wvalid_i && wready_o) begin
                mem[wr_idx] = w_i.data;
                wr_idx <= wr_idx + 10'd1;
                if (w_i.last) begin
                    bvalid_q <= 1'b1;
                end
            end
            if (bvalid_q && bready_i) begin
                bvalid_q <= 1'b0;
            end
        end
    end

endmodule

/* dv/mm_tb.sv */
/*
 * testbench for the matrix-multiply accelerator
 * two operations with random operands and bus checks under random stalls
 */
`timescale 1ns/1ns

module mm_tb;

    // two operations of about 120 cycles each under stalls plus a wide margin
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int NUM_OPS        = 2;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic start = 1'b0;
    logic done;
    logic [31:0] a_addr = '0;
    logic [31:0] b_addr = '0;
    logic [31:0] c_addr = '0;

    mm_pkg::axi_ar_t ar;
    mm_pkg::axi_r_t  r;
    mm_pkg::axi_aw_t aw;
    mm_pkg::axi_w_t  w;
    logic arvalid, arready, rvalid, rready;
    logic awvalid, awready, wvalid, wready, bvalid, bready;

    logic ar_stall = 1'b0;
    logic aw_stall = 1'b0;
    logic w_stall  = 1'b0;
    logic r_bubble = 1'b0;

    logic [31:0] lfsr_q = 32'h7855;

    // per-operation stimulus and reference
    int          a_m [NUM_OPS][4][4];
    int          b_m [NUM_OPS][4][4];
    logic [31:0] exp_c [NUM_OPS][16];
    logic [31:0] a_base [NUM_OPS];
    logic [31:0] b_base [NUM_OPS];
    logic [31:0] c_base [NUM_OPS];
    int          op_q = 0;

    // checker state
    int mismatch_cnt = 0;
    int proto_cnt    = 0;
    int ar_cnt       = 0;
    int aw_cnt       = 0;
    int w_cnt        = 0;
    int w_total      = 0;
    int done_cnt     = 0;
    int cycle_cnt    = 0;
    logic rst_d_q = 1'b0;
    logic ar_hold_q = 1'b0;
    logic aw_hold_q = 1'b0;
    logic w_hold_q = 1'b0;
    mm_pkg::axi_ar_t ar_prev_q;
    mm_pkg::axi_aw_t aw_prev_q;
    mm_pkg::axi_w_t  w_prev_q;

    always #5 clk = ~clk;

    mm_top u_dut (
        .clk (clk), .rst_n (rst_n), .start_i (start), .done_o (done),
        .mat_a_addr_i (a_addr), .mat_b_addr_i (b_addr), .mat_c_addr_i (c_addr),
        .ar_o (ar), .arvalid_o (arvalid), .arready_i (arready),
        .r_i (r), .rvalid_i (rvalid), .rready_o (rready),
        .aw_o (aw), .awvalid_o (awvalid), .awready_i (awready),
        .w_o (w), .wvalid_o (wvalid), .wready_i (wready),
        .bvalid_i (bvalid), .bready_o (bready)
    );

    axi_mem_model u_mem (
        .clk (clk), .rst_n (rst_n),
        .ar_stall_i (ar_stall), .aw_stall_i (aw_stall),
        .w_stall_i (w_stall), .r_bubble_i (r_bubble),
        .ar_i (ar), .arvalid_i (arvalid), .arready_o (arready),
        .r_o (r), .rvalid_o (rvalid), .rready_i (rready),
        .aw_i (aw), .awvalid_i (awvalid), .awready_o (awready),
        .w_i (w), .wvalid_i (wvalid), .wready_o (wready),
        .bvalid_o (bvalid), .bready_i (bready)
    );

    // fibonacci taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one LFSR step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        mismatch_cnt++;
        $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic report_failure(input string what);
        proto_cnt++;
        $display("[ERROR] %0t %s", $time, what);
    endtask

    // stalls on AR, AW and W and bubbles on R at 50 percent each
    always @(posedge clk) begin : stall_gen
        logic [31:0] bits;
        take_bits(4, bits);
        ar_stall <= bits[0];
        aw_stall <= bits[1];
        w_stall  <= bits[2];
        r_bubble <= bits[3];
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, operation did not finish", cycle_cnt);
            $display("Test FAILED");
            $finish;
        end
    end

    // bus checker sampling the values from before the edge
    always @(posedge clk) begin : bus_check
        logic [31:0] exp_addr;
        exp_addr = (ar_cnt == 0) ? a_base[op_q] : b_base[op_q];
        if (!rst_n) begin
            rst_d_q   <= 1'b0;
            ar_hold_q <= 1'b0;
            aw_hold_q <= 1'b0;
            w_hold_q  <= 1'b0;
        end else begin
            rst_d_q <= 1'b1;
            if (!rst_d_q) begin
                assert (!arvalid && !awvalid && !wvalid && !done)
                    else report_failure("valid or done_o high right after reset");
            end
            // stalled channels hold valid and payload
            if (ar_hold_q) assert (arvalid && ar == ar_prev_q)
                else report_failure("AR dropped or changed while stalled");
            if (aw_hold_q) assert (aw_awvalid_ok(awvalid) && aw == aw_prev_q)
                else report_failure("AW dropped or changed while stalled");
            if (w_hold_q) assert (wvalid && w == w_prev_q)
                else report_failure("W dropped or changed while stalled");
            // the DMA engine never back-pressures R or B
            assert (!rvalid || rready)
                else report_failure("rready low while read data is valid");
            assert (!bvalid || bready)
                else report_failure("bready low while a write response is valid");
            ar_hold_q <= arvalid && !arready;
            aw_hold_q <= awvalid && !awready;
            w_hold_q  <= wvalid && !wready;
            ar_prev_q <= ar;
            aw_prev_q <= aw;
            w_prev_q  <= w;

            if (start) begin
                ar_cnt   <= 0;
                aw_cnt   <= 0;
                w_cnt    <= 0;
                done_cnt <= 0;
            end
            // A request first and then B
            if (arvalid && arready) begin
                assert (ar_cnt < 2) else report_failure("more than two AR in one operation");
                assert (ar.id == 1'(ar_cnt)) else report_mismatch("arid", 32'(ar.id), ar_cnt);
                assert (ar.addr == exp_addr) else report_mismatch("araddr", ar.addr, exp_addr);
                assert (ar.len == 4'd15) else report_mismatch("arlen", 32'(ar.len), 32'd15);
                ar_cnt <= ar_cnt + 1;
            end
            if (awvalid && awready) begin
                assert (aw_cnt == 0) else report_failure("more than one AW in one operation");
                assert (aw.addr == c_base[op_q])
                    else report_mismatch("awaddr", aw.addr, c_base[op_q]);
                assert (aw.len == 4'd15) else report_mismatch("awlen", 32'(aw.len), 32'd15);
                aw_cnt <= aw_cnt + 1;
            end
            if (wvalid && wready) begin
                assert (aw_cnt == 1) else report_failure("W beat before its AW");
                assert (w_cnt < 16) else report_failure("more than 16 W beats");
                assert (w.data == exp_c[op_q][w_cnt % 16])
                    else report_mismatch("wdata", w.data, exp_c[op_q][w_cnt % 16]);
                assert (w.last == (w_cnt == 15))
                    else report_mismatch("wlast", 32'(w.last), 32'(w_cnt == 15));
                w_cnt   <= w_cnt + 1;
                w_total <= w_total + 1;
            end
            // done only once and only with the B transfer
            if (done) begin
                assert (bvalid && bready) else report_failure("done_o without a B transfer");
                assert (done_cnt == 0) else report_failure("done_o pulsed twice");
                assert (ar_cnt == 2 && w_cnt == 16)
                    else report_failure("done_o before all AR and W transfers");
                done_cnt <= done_cnt + 1;
            end
        end
    end

    // AW valid as seen by the hold check
    function automatic logic aw_awvalid_ok(input logic v);
        return v;
    endfunction

    initial begin : main
        logic [31:0] bits;
        int acc;
        a_base = '{32'h0000_0100, 32'h0000_0480};
        b_base = '{32'h0000_0200, 32'h0000_0540};
        c_base = '{32'h0000_0300, 32'h0000_0600};
        // signed 8-bit operands and the reference product
        for (int op = 0; op < NUM_OPS; op++) begin
            for (int i = 0; i < 4; i++) begin
                for (int k = 0; k < 4; k++) begin
                    take_bits(8, bits);
                    a_m[op][i][k] = int'($signed(bits[7:0]));
                    take_bits(8, bits);
                    b_m[op][i][k] = int'($signed(bits[7:0]));
                end
            end
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    acc = 0;
                    for (int k = 0; k < 4; k++) begin
                        acc += a_m[op][i][k] * b_m[op][k][j];
                    end
                    exp_c[op][i * 4 + j] = 32'(acc);
                end
            end
        end

        @(posedge clk);
        // A column-major and B row-major
        for (int op = 0; op < NUM_OPS; op++) begin
            for (int k = 0; k < 4; k++) begin
                for (int x = 0; x < 4; x++) begin
                    u_mem.mem[a_base[op][11:2] + 10'(k * 4 + x)] = 32'(a_m[op][x][k]);
                    u_mem.mem[b_base[op][11:2] + 10'(k * 4 + x)] = 32'(b_m[op][k][x]);
                end
            end
        end
        @(posedge clk);
        rst_n <= 1'b1;

        for (int op = 0; op < NUM_OPS; op++) begin
            repeat (3) @(posedge clk);
            start  <= 1'b1;
            a_addr <= a_base[op];
            b_addr <= b_base[op];
            c_addr <= c_base[op];
            op_q   <= op;
            @(posedge clk);
            start <= 1'b0;
            do @(posedge clk); while (done_cnt == 0);
        end
        // room for a stray second done pulse
        repeat (10) @(posedge clk);

        assert (w_total == 16 * NUM_OPS) else report_failure("W beat total is wrong");
        $display("W beats checked: %0d, value mismatches: %0d, protocol errors: %0d",
                 w_total, mismatch_cnt, proto_cnt);
        if (mismatch_cnt == 0 && proto_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+src
src/mm_pkg.sv
src/dma_engine.sv
src/mat_buffer.sv
src/mm_engine.sv
src/mm_top.sv
dv/axi_mem_model.sv
dv/mm_tb.sv
